/* Makefile */
SIM := obj_dir/Vtb_kv_cache

$(SIM): verilog.f $(shell cat verilog.f)
	verilator --binary --timing --assert --top-module tb_kv_cache -f verilog.f -o Vtb_kv_cache

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf obj_dir

.PHONY: run clean

/* rtl/bucket_capture.sv */
`timescale 1ns/1ps
`default_nettype none

module bucket_capture (
	input  wire                                    ui_mig_clk,
	input  wire                                    ui_mig_rst,
	input  wire                                    app_rd_data_valid,
	input  wire  [kv_pkg::line_w-1:0]              app_rd_data,
	input  kv_pkg::pend_entry_t                    pend_head,
	input  logic                                   pend_empty,
	output logic                                   pend_pop,
	output logic                                   cap_valid,
	output logic [kv_pkg::key_w-1:0]               cap_key,
	output kv_pkg::slot_t [kv_pkg::slots-1:0]      cap_slots
);

	// each returned line belongs to the oldest pending get
	assign pend_pop = app_rd_data_valid && !pend_empty;

	always_ff @(posedge ui_mig_clk) begin
		if (ui_mig_rst)
			cap_valid <= 1'b0;
		else
			cap_valid <= app_rd_data_valid;
	end

	always_ff @(posedge ui_mig_clk) begin
		if (app_rd_data_valid) begin
			cap_key <= pend_head;
			for (int i = 0; i < kv_pkg::slots; i++)
				cap_slots[i] <= app_rd_data[i*kv_pkg::slot_w +: kv_pkg::slot_w];
		end
	end

	a_data_has_owner: assert property (@(posedge ui_mig_clk) disable iff (ui_mig_rst)
		app_rd_data_valid |-> !pend_empty);

endmodule

`default_nettype wire

/* rtl/cmd_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_arbiter (
	input  wire                          ui_mig_clk,
	input  wire                          ui_mig_rst,
	input  kv_pkg::wr_entry_t            wr_head,
	input  logic                         wr_empty,
	output logic                         wr_pop,
	input  logic [kv_pkg::addr_w-1:0]    rd_head,
	input  logic                         rd_empty,
	output logic                         rd_pop,
	input  wire                          app_rdy,
	input  wire                          app_wdf_rdy,
	output logic                         app_en,
	output logic [2:0]                   app_cmd,
	output logic [kv_pkg::addr_w-1:0]    app_addr,
	output logic                         app_wdf_wren,
	output logic                         app_wdf_end,
	output logic [kv_pkg::line_w-1:0]    app_wdf_data,
	output logic [kv_pkg::mask_w-1:0]    app_wdf_mask
);

	logic can_wr;
	logic can_rd;
	logic sel_wr;
	logic sel_rd;
	// high means writes go first when both compete
	logic wr_turn;
	logic [kv_pkg::slot_idx_w-1:0] wr_slot;
	logic [kv_pkg::line_w-1:0]     wide_slot;
	logic [kv_pkg::mask_w-1:0]     slot_bytes;

	assign can_wr = !wr_empty && app_rdy && app_wdf_rdy;
	assign can_rd = !rd_empty && app_rdy;
	assign sel_wr = can_wr && (!can_rd || wr_turn);
	assign sel_rd = can_rd && (!can_wr || !wr_turn);

	always_ff @(posedge ui_mig_clk) begin
		if (ui_mig_rst)
			wr_turn <= 1'b0;
		else if (can_wr && can_rd)
			wr_turn <= !wr_turn;
	end

	// ----------------------------------------
	// memory command
	// ----------------------------------------
	assign app_en   = sel_wr || sel_rd;
	assign app_cmd  = sel_wr ? kv_pkg::cmd_write : kv_pkg::cmd_read;
	assign app_addr = sel_wr ? wr_head[kv_pkg::wr_addr_lsb +: kv_pkg::addr_w] : rd_head;
	assign wr_pop   = sel_wr;
	assign rd_pop   = sel_rd;

	// place the slot and mask off the other slots
	assign wr_slot    = wr_head[kv_pkg::wr_slot_lsb +: kv_pkg::slot_idx_w];
	assign wide_slot  = {{(kv_pkg::line_w - kv_pkg::slot_w){1'b0}},
		wr_head[kv_pkg::wr_slot_lsb-1:0]};
	assign slot_bytes = {{(kv_pkg::mask_w - kv_pkg::slot_w / 8){1'b0}},
		{(kv_pkg::slot_w / 8){1'b1}}};

	assign app_wdf_data = wide_slot << (wr_slot * kv_pkg::slot_w);
	assign app_wdf_mask = ~(slot_bytes << (wr_slot * (kv_pkg::slot_w / 8)));
	assign app_wdf_wren = sel_wr;
	assign app_wdf_end  = sel_wr;

	a_wr_needs_wdf_rdy: assert property (@(posedge ui_mig_clk) disable iff (ui_mig_rst)
		(app_en && app_cmd == kv_pkg::cmd_write) |-> (app_wdf_rdy && app_wdf_wren));

endmodule

`default_nettype wire

/* rtl/hit_resolver.sv */
`timescale 1ns/1ps
`default_nettype none

module hit_resolver (
	input  wire                                        ui_mig_clk,
	input  wire                                        ui_mig_rst,
	input  logic                                       stage_valid,
	input  logic [kv_pkg::slots-1:0]                   match,
	input  logic [kv_pkg::slots-1:0][kv_pkg::val_w-1:0] slot_value,
	output logic                                       out_valid,
	output logic [3:0]                                 out_flag,
	output logic [kv_pkg::val_w-1:0]                   out_value
);

	logic                     hit;
	logic [kv_pkg::val_w-1:0] sel_value;

	// walk downward so the lowest matching slot wins
	always_comb begin
		hit       = 1'b0;
		sel_value = '0;
		for (int i = kv_pkg::slots - 1; i >= 0; i--) begin
			if (match[i]) begin
				hit       = 1'b1;
				sel_value = slot_value[i];
			end
		end
	end

	always_ff @(posedge ui_mig_clk) begin
		if (ui_mig_rst)
			out_valid <= 1'b0;
		else
			out_valid <= stage_valid;
	end

	// miss returns zero value
	always_ff @(posedge ui_mig_clk) begin
		out_flag  <= {3'b000, stage_valid && hit};
		out_value <= (stage_valid && hit) ? sel_value : '0;
	end

	a_single_match: assert property (@(posedge ui_mig_clk) disable iff (ui_mig_rst)
		stage_valid |-> $onehot0(match));

endmodule

`default_nettype wire

/* rtl/kv_cache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module kv_cache_top #(
	parameter int queue_depth = 16
) (
	input  wire                          ui_mig_clk,
	input  wire                          ui_mig_rst,
	// host requests
	input  wire                          in_valid,
	input  wire                          in_op,
	input  wire  [kv_pkg::hash_w-1:0]    in_hash,
	input  wire  [kv_pkg::key_w-1:0]     in_key,
	input  wire  [kv_pkg::val_w-1:0]     in_value,
	output logic                         in_ready,
	// memory controller user side
	output logic                         app_en,
	output logic [2:0]                   app_cmd,
	output logic [kv_pkg::addr_w-1:0]    app_addr,
	input  wire                          app_rdy,
	output logic                         app_wdf_wren,
	output logic                         app_wdf_end,
	output logic [kv_pkg::line_w-1:0]    app_wdf_data,
	output logic [kv_pkg::mask_w-1:0]    app_wdf_mask,
	input  wire                          app_wdf_rdy,
	input  wire                          app_rd_data_valid,
	input  wire  [kv_pkg::line_w-1:0]    app_rd_data,
	// responses
	output logic                         out_valid,
	output logic [3:0]                   out_flag,
	output logic [kv_pkg::val_w-1:0]     out_value
);

	logic accept;
	logic set_push;
	logic get_push;
	logic [kv_pkg::addr_w-1:0] bucket_addr;
	kv_pkg::wr_entry_t         wr_entry;

	kv_pkg::wr_entry_t         wr_head;
	logic                      wr_empty, wr_full, wr_pop;
	logic [kv_pkg::addr_w-1:0] rd_head;
	logic                      rd_empty, rd_full, rd_pop;
	kv_pkg::pend_entry_t       pend_head;
	logic                      pend_empty, pend_full, pend_pop;

	logic                                cap_valid;
	logic [kv_pkg::key_w-1:0]            cap_key;
	kv_pkg::slot_t [kv_pkg::slots-1:0]   cap_slots;
	logic                                stage_valid;
	logic [kv_pkg::slots-1:0]            match;
	logic [kv_pkg::slots-1:0][kv_pkg::val_w-1:0] slot_value;

	// ----------------------------------------
	// request intake
	// ----------------------------------------
	assign in_ready = !wr_full && !rd_full && !pend_full;
	assign accept   = in_valid && in_ready;
	assign set_push = accept && (in_op == kv_pkg::op_set);
	assign get_push = accept && (in_op == kv_pkg::op_get);

	// bucket base is 64-byte aligned
	assign bucket_addr = {in_hash[kv_pkg::addr_w-1:kv_pkg::bucket_lsb],
		{kv_pkg::bucket_lsb{1'b0}}};
	assign wr_entry = {bucket_addr, in_hash[kv_pkg::slot_idx_w-1:0], in_key, in_value};

	req_queue #(
		.queue_depth (queue_depth),
		.payload_t   (kv_pkg::wr_entry_t)
	) u_wr_queue (
		.ui_mig_clk (ui_mig_clk),
		.ui_mig_rst (ui_mig_rst),
		.push       (set_push),
		.push_data  (wr_entry),
		.pop        (wr_pop),
		.head       (wr_head),
		.empty      (wr_empty),
		.full       (wr_full)
	);

	req_queue #(
		.queue_depth (queue_depth),
		.payload_t   (logic [kv_pkg::addr_w-1:0])
	) u_rd_queue (
		.ui_mig_clk (ui_mig_clk),
		.ui_mig_rst (ui_mig_rst),
		.push       (get_push),
		.push_data  (bucket_addr),
		.pop        (rd_pop),
		.head       (rd_head),
		.empty      (rd_empty),
		.full       (rd_full)
	);

	// keys wait here until their bucket comes back
	req_queue #(
		.queue_depth (queue_depth),
		.payload_t   (kv_pkg::pend_entry_t)
	) u_pend_queue (
		.ui_mig_clk (ui_mig_clk),
		.ui_mig_rst (ui_mig_rst),
		.push       (get_push),
		.push_data  (in_key),
		.pop        (pend_pop),
		.head       (pend_head),
		.empty      (pend_empty),
		.full       (pend_full)
	);

	cmd_arbiter u_cmd_arbiter (
		.ui_mig_clk   (ui_mig_clk),
		.ui_mig_rst   (ui_mig_rst),
		.wr_head      (wr_head),
		.wr_empty     (wr_empty),
		.wr_pop       (wr_pop),
		.rd_head      (rd_head),
		.rd_empty     (rd_empty),
		.rd_pop       (rd_pop),
		.app_rdy      (app_rdy),
		.app_wdf_rdy  (app_wdf_rdy),
		.app_en       (app_en),
		.app_cmd      (app_cmd),
		.app_addr     (app_addr),
		.app_wdf_wren (app_wdf_wren),
		.app_wdf_end  (app_wdf_end),
		.app_wdf_data (app_wdf_data),
		.app_wdf_mask (app_wdf_mask)
	);

	// ----------------------------------------
	// lookup pipeline
	// ----------------------------------------
	bucket_capture u_bucket_capture (
		.ui_mig_clk        (ui_mig_clk),
		.ui_mig_rst        (ui_mig_rst),
		.app_rd_data_valid (app_rd_data_valid),
		.app_rd_data       (app_rd_data),
		.pend_head         (pend_head),
		.pend_empty        (pend_empty),
		.pend_pop          (pend_pop),
		.cap_valid         (cap_valid),
		.cap_key           (cap_key),
		.cap_slots         (cap_slots)
	);

	for (genvar g = 0; g < kv_pkg::slots; g++) begin : g_slot
		slot_compare u_slot_compare (
			.ui_mig_clk (ui_mig_clk),
			.ui_mig_rst (ui_mig_rst),
			.cap_valid  (cap_valid),
			.cap_key    (cap_key),
			.slot       (cap_slots[g]),
			.match      (match[g]),
			.slot_value (slot_value[g])
		);
	end

	// keep valid aligned with the comparator stage
	always_ff @(posedge ui_mig_clk) begin
		if (ui_mig_rst)
			stage_valid <= 1'b0;
		else
			stage_valid <= cap_valid;
	end

	hit_resolver u_hit_resolver (
		.ui_mig_clk  (ui_mig_clk),
		.ui_mig_rst  (ui_mig_rst),
		.stage_valid (stage_valid),
		.match       (match),
		.slot_value  (slot_value),
		.out_valid   (out_valid),
		.out_flag    (out_flag),
		.out_value   (out_value)
	);

endmodule

`default_nettype wire

/* rtl/kv_pkg.sv */
`default_nettype none

package kv_pkg;

	// ----------------------------------------
	// table geometry
	// ----------------------------------------
	localparam int key_w      = 96;
	localparam int val_w      = 32;
	localparam int slot_w     = key_w + val_w;
	localparam int slots      = 4;
	localparam int line_w     = slot_w * slots;
	localparam int mask_w     = line_w / 8;
	localparam int addr_w     = 30;
	localparam int hash_w     = 32;
	// bucket index sits above these zero bits
	localparam int bucket_lsb = 6;
	localparam int slot_idx_w = $clog2(slots);

	// memory controller command codes
	localparam logic [2:0] cmd_write = 3'd0;
	localparam logic [2:0] cmd_read  = 3'd1;

	// request opcodes
	localparam logic op_set = 1'b1;
	localparam logic op_get = 1'b0;

	// write entry layout with the value at the bottom
	localparam int wr_key_lsb  = val_w;
	localparam int wr_slot_lsb = val_w + key_w;
	localparam int wr_addr_lsb = wr_slot_lsb + slot_idx_w;
	localparam int wr_entry_w  = wr_addr_lsb + addr_w;

	typedef logic [slot_w-1:0]     slot_t;
	typedef logic [wr_entry_w-1:0] wr_entry_t;
	typedef logic [key_w-1:0]      pend_entry_t;

endpackage

`default_nettype wire

/* rtl/req_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module req_queue #(
	parameter int  queue_depth = 16,
	parameter type payload_t   = logic
) (
	input  wire      ui_mig_clk,
	input  wire      ui_mig_rst,
	input  logic     push,
	input  payload_t push_data,
	input  logic     pop,
	output payload_t head,
	output logic     empty,
	output logic     full
);

	localparam int ptr_w = $clog2(queue_depth);

	payload_t mem [queue_depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [ptr_w:0]   count;

	// entry storage
	always_ff @(posedge ui_mig_clk) begin
		if (push)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge ui_mig_clk) begin
		if (ui_mig_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			// simultaneous push and pop leaves occupancy alone
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	assign head  = mem[rd_ptr];
	assign empty = (count == '0);
	assign full  = (count == queue_depth[ptr_w:0]);

	a_no_overflow: assert property (@(posedge ui_mig_clk) disable iff (ui_mig_rst)
		push |-> !full);
	a_no_underflow: assert property (@(posedge ui_mig_clk) disable iff (ui_mig_rst)
		pop |-> !empty);

endmodule

`default_nettype wire

/* rtl/slot_compare.sv */
`timescale 1ns/1ps
`default_nettype none

module slot_compare (
	input  wire                       ui_mig_clk,
	input  wire                       ui_mig_rst,
	input  logic                      cap_valid,
	input  logic [kv_pkg::key_w-1:0]  cap_key,
	input  kv_pkg::slot_t             slot,
	output logic                      match,
	output logic [kv_pkg::val_w-1:0]  slot_value
);

	// key in the upper part of the slot
	always_ff @(posedge ui_mig_clk) begin
		if (ui_mig_rst)
			match <= 1'b0;
		else
			match <= cap_valid && (slot[kv_pkg::slot_w-1:kv_pkg::val_w] == cap_key);
	end

	always_ff @(posedge ui_mig_clk) begin
		slot_value <= slot[kv_pkg::val_w-1:0];
	end

endmodule

`default_nettype wire

/* sim/tb_dram_model.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dram_model (
	input  wire          ui_mig_clk,
	input  wire          ui_mig_rst,
	input  wire          app_en,
	input  wire  [2:0]   app_cmd,
	input  wire  [29:0]  app_addr,
	output logic         app_rdy = 1'b0,
	input  wire          app_wdf_wren,
	input  wire          app_wdf_end,
	input  wire  [511:0] app_wdf_data,
	input  wire  [63:0]  app_wdf_mask,
	output logic         app_wdf_rdy = 1'b0,
	output logic         app_rd_data_valid = 1'b0,
	output logic [511:0] app_rd_data = '0
);

	localparam int read_delay = 4;

	logic [511:0] mem [1024];
	logic [511:0] pipe_data [read_delay];
	logic [read_delay-1:0] pipe_valid = '0;
	logic [31:0] rng_state = 32'd35161;
	logic [9:0] line;
	logic wr_take;

	function automatic logic [31:0] next_rand(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// backdoor write of one slot with the key above the value
	task automatic preload_slot(input int line_idx, input int slot_idx,
		input logic [95:0] key, input logic [31:0] value);
		mem[line_idx][slot_idx*128 +: 128] = {key, value};
	endtask

	// 64-byte lines
	assign line = app_addr[15:6];

	// a single-beat write carries its data in the command cycle
	assign wr_take = app_en && app_rdy && app_cmd == kv_pkg::cmd_write &&
		app_wdf_wren && app_wdf_end && app_wdf_rdy;

	always @(posedge ui_mig_clk) begin
		if (ui_mig_rst) begin
			pipe_valid <= '0;
			app_rd_data_valid <= #1 1'b0;
		end else begin
			// mask bit set keeps the stored byte
			if (wr_take) begin
				for (int b = 0; b < 64; b++) begin
					if (!app_wdf_mask[b])
						mem[line][b*8 +: 8] = app_wdf_data[b*8 +: 8];
				end
			end
			pipe_valid <= {pipe_valid[read_delay-2:0],
				app_en && app_rdy && app_cmd == kv_pkg::cmd_read};
			pipe_data[0] <= mem[line];
			for (int i = read_delay - 1; i > 0; i--)
				pipe_data[i] <= pipe_data[i-1];
			app_rd_data_valid <= #1 pipe_valid[read_delay-1];
			app_rd_data <= #1 pipe_data[read_delay-1];
		end
		// roughly one stall in four on each ready
		rng_state = next_rand(rng_state);
		app_rdy <= #1 (rng_state[17:16] != 2'b00);
		app_wdf_rdy <= #1 (rng_state[21:20] != 2'b00);
	end

endmodule

`default_nettype wire

/* sim/tb_kv_cache.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_kv_cache;

	localparam int buckets = 1024;
	// requests in set_then_get, get_miss, slot_isolation, overwrite and stall_stream
	localparam int req_total = 8 + 1 + 5 + 5 + 60;
	localparam int timeout_cycles = req_total * 40;

	logic ui_mig_clk = 1'b0;
	logic ui_mig_rst;
	logic in_valid;
	logic in_op;
	logic [31:0] in_hash;
	logic [95:0] in_key;
	logic [31:0] in_value;
	logic in_ready;
	logic app_en;
	logic [2:0] app_cmd;
	logic [29:0] app_addr;
	logic app_rdy;
	logic app_wdf_wren;
	logic app_wdf_end;
	logic [511:0] app_wdf_data;
	logic [63:0] app_wdf_mask;
	logic app_wdf_rdy;
	logic app_rd_data_valid;
	logic [511:0] app_rd_data;
	logic out_valid;
	logic [3:0] out_flag;
	logic [31:0] out_value;

	// reference table of the whole memory
	logic [95:0] ref_key [buckets][4];
	logic [31:0] ref_val [buckets][4];
	logic [35:0] exp_q [$];
	logic [35:0] resp_log [256];
	logic [31:0] rng_state = 32'd35161;
	int resp_total = 0;
	int writes_seen = 0;
	int reads_seen = 0;
	int cycles = 0;
	int resp_checked = 0;
	int sets_sent = 0;
	int gets_sent = 0;
	int checks = 0;
	int errors = 0;

	always #50 ui_mig_clk = !ui_mig_clk;

	kv_cache_top #(
		.queue_depth (16)
	) u_kv_cache_top (
		.ui_mig_clk        (ui_mig_clk),
		.ui_mig_rst        (ui_mig_rst),
		.in_valid          (in_valid),
		.in_op             (in_op),
		.in_hash           (in_hash),
		.in_key            (in_key),
		.in_value          (in_value),
		.in_ready          (in_ready),
		.app_en            (app_en),
		.app_cmd           (app_cmd),
		.app_addr          (app_addr),
		.app_rdy           (app_rdy),
		.app_wdf_wren      (app_wdf_wren),
		.app_wdf_end       (app_wdf_end),
		.app_wdf_data      (app_wdf_data),
		.app_wdf_mask      (app_wdf_mask),
		.app_wdf_rdy       (app_wdf_rdy),
		.app_rd_data_valid (app_rd_data_valid),
		.app_rd_data       (app_rd_data),
		.out_valid         (out_valid),
		.out_flag          (out_flag),
		.out_value         (out_value)
	);

	tb_dram_model u_dram_model (
		.ui_mig_clk        (ui_mig_clk),
		.ui_mig_rst        (ui_mig_rst),
		.app_en            (app_en),
		.app_cmd           (app_cmd),
		.app_addr          (app_addr),
		.app_rdy           (app_rdy),
		.app_wdf_wren      (app_wdf_wren),
		.app_wdf_end       (app_wdf_end),
		.app_wdf_data      (app_wdf_data),
		.app_wdf_mask      (app_wdf_mask),
		.app_wdf_rdy       (app_wdf_rdy),
		.app_rd_data_valid (app_rd_data_valid),
		.app_rd_data       (app_rd_data)
	);

	// ----------------------------------------
	// monitors and timeout
	// ----------------------------------------
	always @(posedge ui_mig_clk) begin
		if (out_valid) begin
			resp_log[resp_total[7:0]] <= {out_flag, out_value};
			resp_total <= resp_total + 1;
		end
		if (app_en && app_rdy) begin
			if (app_cmd == kv_pkg::cmd_write)
				writes_seen <= writes_seen + 1;
			else
				reads_seen <= reads_seen + 1;
		end
	end

	always @(posedge ui_mig_clk) begin
		cycles <= cycles + 1;
		if (cycles == timeout_cycles) begin
			$display("timeout: tests still running after %0d cycles", timeout_cycles);
			$display("Testbench failed");
			$finish;
		end
	end

	// ----------------------------------------
	// helpers
	// ----------------------------------------
	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// bits 31..30 and 5..2 are don't-care in the hash
	function automatic logic [31:0] hash_of(input int bucket, input int slot);
		return (32'(bucket) << 6) | 32'hc000_0024 | 32'(slot);
	endfunction

	// lowest matching slot wins
	function automatic logic [35:0] predict(input int bucket, input logic [95:0] key);
		for (int s = 0; s < 4; s++) begin
			if (ref_key[bucket][s] == key)
				return {4'b0001, ref_val[bucket][s]};
		end
		return 36'd0;
	endfunction

	task automatic wait_cycle();
		@(posedge ui_mig_clk);
		#1;
	endtask

	// called 1 ns after a rising edge, returns likewise
	task automatic drive_req(input logic op, input logic [31:0] hash,
		input logic [95:0] key, input logic [31:0] value);
		in_valid = 1'b1;
		in_op    = op;
		in_hash  = hash;
		in_key   = key;
		in_value = value;
		while (!in_ready)
			wait_cycle();
		wait_cycle();
		in_valid = 1'b0;
	endtask

	task automatic preload(input int bucket, input int slot,
		input logic [95:0] key, input logic [31:0] value);
		u_dram_model.preload_slot(bucket, slot, key, value);
		ref_key[bucket][slot] = key;
		ref_val[bucket][slot] = value;
	endtask

	// older gets must reach memory before a write can overtake them
	task automatic send_set(input int bucket, input int slot,
		input logic [95:0] key, input logic [31:0] value);
		while (reads_seen != gets_sent)
			wait_cycle();
		drive_req(kv_pkg::op_set, hash_of(bucket, slot), key, value);
		ref_key[bucket][slot] = key;
		ref_val[bucket][slot] = value;
		sets_sent++;
	endtask

	task automatic send_get(input int bucket, input logic [95:0] key);
		while (writes_seen != sets_sent)
			wait_cycle();
		exp_q.push_back(predict(bucket, key));
		drive_req(kv_pkg::op_get, hash_of(bucket, 3), key, 32'd0);
		gets_sent++;
	endtask

	task automatic check_responses(input string name);
		int n;
		int fails_before;
		logic [35:0] exp_word;
		logic [35:0] got_word;
		fails_before = errors;
		n = exp_q.size();
		while (resp_total - resp_checked < n)
			wait_cycle();
		while (exp_q.size() > 0) begin
			exp_word = exp_q.pop_front();
			got_word = resp_log[resp_checked[7:0]];
			resp_checked++;
			checks += 2;
			assert (got_word[35:32] == exp_word[35:32]) else begin
				$display("Fail %s: flag expected %0d actual %0d", name,
					exp_word[35:32], got_word[35:32]);
				errors++;
			end
			assert (got_word[31:0] == exp_word[31:0]) else begin
				$display("Fail %s: value expected %08h actual %08h", name,
					exp_word[31:0], got_word[31:0]);
				errors++;
			end
		end
		// settle, then look for stray responses
		repeat (4) wait_cycle();
		checks++;
		assert (resp_total == resp_checked) else begin
			$display("Fail %s: response count expected %0d actual %0d", name,
				resp_checked, resp_total);
			errors++;
		end
		if (errors == fails_before)
			$display("%s: pass, %0d responses", name, n);
		else
			$display("%s: %0d errors", name, errors - fails_before);
	endtask

	// ----------------------------------------
	// directed tests
	// ----------------------------------------
	task automatic set_then_get();
		logic [95:0] key;
		for (int s = 0; s < 4; s++) begin
			key = {32'h1000_0000 + 32'(s), 64'h0123_4567_89ab_cdef};
			send_set(10, s, key, 32'hc0de_0000 + 32'(s));
			send_get(10, key);
		end
		check_responses("set_then_get");
	endtask

	task automatic get_miss();
		send_get(30, {32'hdead_0000, 64'h0});
		check_responses("get_miss");
	endtask

	task automatic slot_isolation();
		preload(20, 0, {32'h2000_0000, 64'h0}, 32'h1111_0000);
		preload(20, 1, {32'h2000_0001, 64'h0}, 32'h1111_0001);
		preload(20, 3, {32'h2000_0003, 64'h0}, 32'h1111_0003);
		send_set(20, 2, {32'h2000_0002, 64'h0}, 32'h1111_0002);
		for (int s = 0; s < 4; s++)
			send_get(20, {32'h2000_0000 + 32'(s), 64'h0});
		check_responses("slot_isolation");
	endtask

	task automatic overwrite();
		send_set(40, 1, {32'h3000_000a, 64'h0}, 32'haaaa_aaaa);
		send_get(40, {32'h3000_000a, 64'h0});
		send_set(40, 1, {32'h3000_000b, 64'h0}, 32'hbbbb_bbbb);
		send_get(40, {32'h3000_000a, 64'h0});
		send_get(40, {32'h3000_000b, 64'h0});
		check_responses("overwrite");
	endtask

	task automatic stall_stream();
		logic [95:0] keys [60];
		int key_bucket [60];
		int stored;
		int idx;
		logic [95:0] key;
		stored = 0;
		for (int n = 0; n < 60; n++) begin
			rng_state = lcg_next(rng_state);
			if (stored == 0 || rng_state[24]) begin
				key = {16'h5eed, 16'(n), rng_state, ~rng_state};
				keys[stored] = key;
				key_bucket[stored] = 100 + int'(rng_state[18:16]);
				send_set(key_bucket[stored], int'(rng_state[21:20]), key,
					rng_state ^ 32'h3c3c_0f0f);
				stored++;
			end else if (rng_state[27:26] == 2'b00) begin
				send_get(100 + int'(rng_state[18:16]), {16'hdead, 16'(n), 64'h0});
			end else begin
				rng_state = lcg_next(rng_state);
				idx = int'(rng_state[23:16]) % stored;
				send_get(key_bucket[idx], keys[idx]);
			end
		end
		check_responses("stall_stream");
	endtask

	initial begin
		ui_mig_rst = 1'b1;
		in_valid   = 1'b0;
		in_op      = 1'b0;
		in_hash    = '0;
		in_key     = '0;
		in_value   = '0;
		// every slot gets a key unique to its bucket and slot
		for (int b = 0; b < buckets; b++) begin
			for (int s = 0; s < 4; s++)
				preload(b, s, {32'hf11e_d000, 32'(b), 32'(s)}, 32'(b * 4 + s) ^ 32'h5a5a_0000);
		end
		repeat (8) @(posedge ui_mig_clk);
		#1;
		ui_mig_rst = 1'b0;
		wait_cycle();
		set_then_get();
		get_miss();
		slot_isolation();
		overwrite();
		stall_stream();
		$display("summary: %0d checks, %0d failed", checks, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
rtl/kv_pkg.sv
rtl/req_queue.sv
rtl/cmd_arbiter.sv
rtl/bucket_capture.sv
rtl/slot_compare.sv
rtl/hit_resolver.sv
rtl/kv_cache_top.sv
sim/tb_dram_model.sv
sim/tb_kv_cache.sv
